// ==== project.f ====
+incdir+.
ebus_pkg.sv
ebus_cmd_decode.sv
edp_slice.sv
ebus_collect.sv
ebus_diag.sv
ebus_diag_tb.sv

// ==== ebus_diag_tb.sv ====
`include "ebus_config.svh"

module ebus_diag_tb
  import ebus_pkg::*;
();

  localparam int clk_period = 100;
  localparam int drive_delay = 10;
  localparam int accept_limit = 64;
  localparam int drain_limit = 256;
  localparam int random_cmds = 300;

  logic       clk;
  logic       reset;
  ebus_cmd_t  cmd;
  logic       cmd_valid;
  logic       cmd_ready;
  ebus_resp_t resp;
  logic       resp_valid;
  logic       resp_ready;

  int         seed;
  logic       stall_mode;
  logic       lat_check;
  ebus_resp_t held_resp;

  // Reference copy of the eight registers and the reads still owed
  logic [word_w-1:0] model [`EBUS_REGS];
  logic [word_w-1:0] expected_q [$];
  logic [word_w-1:0] expected_head;
  int                expected_count;

  ebus_diag DUT (
    .clk        (clk),
    .reset      (reset),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1);
  endtask

  function automatic logic [word_w-1:0] random_word();
    logic [63:0] bits;
    bits = {$random(seed), $random(seed)};
    return bits[word_w-1:0];
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
    if (stall_mode) begin
      resp_ready = ($unsigned($random(seed)) % 3) != 0;
    end else begin
      resp_ready = 1'b1;
    end
  endtask

  task automatic issue(input ebus_func_e func, input logic [sel_w-1:0] sel,
                       input logic [word_w-1:0] data);
    int   cycles;
    logic taken;
    cycles = 0;
    taken = 1'b0;
    cmd.func = func;
    cmd.sel = sel;
    cmd.data.word = data;
    cmd_valid = 1'b1;
    while (!taken) begin
      @(negedge clk);
      taken = cmd_ready;
      next_cycle();
      cycles++;
      if (!taken && cycles == accept_limit) begin
        report_failure("timed out waiting for cmd_ready to accept a command");
      end
    end
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (expected_count != 0) begin
      if (cycles == drain_limit) begin
        report_failure("timed out waiting for outstanding read responses");
      end
      next_cycle();
      cycles++;
    end
  endtask

  task automatic read_back(input logic [sel_w-1:0] sel);
    issue(func_read, sel, random_word());
    wait_drain();
  endtask

  // Write rules of the bus, applied in acceptance order
  task automatic apply_command(input ebus_cmd_t c);
    logic [word_w-1:0] d;
    d = c.data.word;
    case (c.func)
      func_read:        expected_q.push_back(model[c.sel]);
      func_write:       model[c.sel] = d;
      func_write_left:  model[c.sel][word_w-1:half_w] = d[word_w-1:half_w];
      func_write_right: model[c.sel][half_w-1:0] = d[half_w-1:0];
      func_write_swap:  model[c.sel] = {d[half_w-1:0], d[word_w-1:half_w]};
      default: ;
    endcase
  endtask

  always @(posedge clk) begin
    held_resp <= resp;
    if (!reset) begin
      if (resp_valid && resp_ready && expected_q.size() != 0) begin
        void'(expected_q.pop_front());
      end
      if (cmd_valid && cmd_ready) begin
        apply_command(cmd);
      end
      expected_count = expected_q.size();
      if (expected_count != 0) begin
        expected_head = expected_q[0];
      end
    end
  end

  a_reset_idle: assert property (@(negedge clk) reset |-> !resp_valid)
    else report_failure("resp_valid went high while reset was held");

  a_latency: assert property (@(posedge clk) disable iff (reset)
      (lat_check && cmd_valid && cmd_ready && cmd.func == func_read)
      |-> ##1 !resp_valid ##1 !resp_valid ##1 resp_valid)
    else report_failure("read response did not arrive exactly 3 cycles after accept");

  a_resp_expected: assert property (@(posedge clk) disable iff (reset)
      (resp_valid && resp_ready) |-> expected_count != 0)
    else report_failure("a response arrived with no read outstanding");

  a_resp_word: assert property (@(posedge clk) disable iff (reset)
      (resp_valid && resp_ready && expected_count != 0) |-> resp.word.word == expected_head)
    else report_failure($sformatf("mismatch resp.word got %h expected %h",
      $sampled(resp.word.word), $sampled(expected_head)));

  // Odd weight over the word and its parity bit
  a_resp_parity: assert property (@(posedge clk) disable iff (reset)
      resp_valid |-> ^{resp.word.word, resp.par})
    else report_failure($sformatf("mismatch resp.par got %h expected %h",
      $sampled(resp.par), $sampled(~^resp.word.word)));

  a_stall_blocks_cmd: assert property (@(posedge clk) disable iff (reset)
      (resp_valid && !resp_ready) |-> !cmd_ready)
    else report_failure($sformatf("mismatch cmd_ready got %h expected %h",
      $sampled(cmd_ready), 1'b0));

  a_stall_holds_valid: assert property (@(posedge clk) disable iff (reset)
      (resp_valid && !resp_ready) |=> resp_valid)
    else report_failure("resp_valid dropped while the response was stalled");

  a_stall_holds_resp: assert property (@(posedge clk) disable iff (reset)
      (resp_valid && !resp_ready) |=> resp == held_resp)
    else report_failure($sformatf("mismatch resp got %h expected %h",
      $sampled(resp), $sampled(held_resp)));

  initial begin
    int func_code;
    int sel_code;
    seed = 32'he252_575c;
    clk = 1'b0;
    reset = 1'b1;
    cmd = '0;
    cmd_valid = 1'b0;
    resp_ready = 1'b0;
    stall_mode = 1'b0;
    lat_check = 1'b1;
    expected_count = 0;
    expected_head = '0;
    for (int r = 0; r < `EBUS_REGS; r++) begin
      model[r] = '0;
    end
    repeat (2) @(posedge clk);
    #drive_delay;
    reset = 1'b0;
    resp_ready = 1'b1;

    for (int r = 0; r < `EBUS_REGS; r++) begin
      read_back(sel_w'(r));
    end
    for (int r = 0; r < `EBUS_REGS; r++) begin
      issue(func_write, sel_w'(r), random_word());
      read_back(sel_w'(r));
    end
    issue(func_write_left, 3'd2, random_word());
    read_back(3'd2);
    issue(func_write_right, 3'd6, random_word());
    read_back(3'd6);
    issue(func_write_swap, 3'd5, random_word());
    read_back(3'd5);

    // Back-to-back traffic with the response side stalling at random
    lat_check = 1'b0;
    stall_mode = 1'b1;
    for (int n = 0; n < random_cmds; n++) begin
      func_code = $unsigned($random(seed)) % 5;
      sel_code = $unsigned($random(seed)) % `EBUS_REGS;
      issue(ebus_func_e'(func_code[2:0]), sel_w'(sel_code), random_word());
    end
    stall_mode = 1'b0;
    wait_drain();

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== ebus_diag.sv ====
`include "ebus_config.svh"

module ebus_diag
  import ebus_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  ebus_cmd_t  cmd,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  output ebus_resp_t resp,
  output logic       resp_valid,
  input  logic       resp_ready
);

  ebus_strobe_t strobe;
  ebus_driver_t drivers [`EBUS_SLICES];
  logic         advance;

  ebus_cmd_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .advance   (advance),
    .strobe    (strobe)
  );

  // One board per six-bit slice of the word
  for (genvar k = 0; k < `EBUS_SLICES; k++) begin : g_slice
    edp_slice #(
      .slice_index (k)
    ) u_slice (
      .clk     (clk),
      .reset   (reset),
      .advance (advance),
      .strobe  (strobe),
      .driver  (drivers[k])
    );
  end

  ebus_collect u_collect (
    .clk        (clk),
    .reset      (reset),
    .drivers    (drivers),
    .advance    (advance),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

endmodule

// ==== ebus_collect.sv ====
`include "ebus_config.svh"

module ebus_collect
  import ebus_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  ebus_driver_t drivers [`EBUS_SLICES],
  output logic         advance,
  output ebus_resp_t   resp,
  output logic         resp_valid,
  input  logic         resp_ready
);

  logic       any_driving;
  ebus_word_u bus_word;
  logic       bus_par;

  always_comb begin
    any_driving = 1'b0;
    for (int k = 0; k < `EBUS_SLICES; k++) begin
      any_driving = any_driving | drivers[k].driving;
    end
  end

  // Slice 0 lands in the low bits, the last slice in the high bits
  always_comb begin
    bus_word.word = '0;
    for (int k = 0; k < `EBUS_SLICES; k++) begin
      bus_word.word[k*`EBUS_SLICE_W +: `EBUS_SLICE_W] = drivers[k].data;
    end
  end

  // Odd parity over word plus par
  assign bus_par = ~^bus_word.word;

  // Whole pipeline steps only when the output slot can take a word
  assign advance = !resp_valid || resp_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else if (advance) begin
      resp_valid <= any_driving;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && any_driving) begin
      resp.word <= bus_word;
      resp.par <= bus_par;
    end
  end

endmodule

// ==== edp_slice.sv ====
`include "ebus_config.svh"

module edp_slice
  import ebus_pkg::*;
#(
  parameter int slice_index = 0
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         advance,
  input  ebus_strobe_t strobe,
  output ebus_driver_t driver
);

  localparam int lsb = slice_index * `EBUS_SLICE_W;

  logic [`EBUS_SLICE_W-1:0] regs [`EBUS_REGS];
  logic [`EBUS_SLICE_W-1:0] wslice;
  logic                     write_hit;
  logic                     driving_q;
  logic [`EBUS_SLICE_W-1:0] data_q;

  // This board only sees its own six bits of the word
  assign wslice = strobe.wdata.word[lsb +: `EBUS_SLICE_W];
  assign write_hit = advance && strobe.valid && strobe.wen[slice_index];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < `EBUS_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (write_hit) begin
      regs[strobe.sel] <= wslice;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      driving_q <= 1'b0;
    end else if (advance) begin
      driving_q <= strobe.valid && strobe.read;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      data_q <= regs[strobe.sel];
    end
  end

  always_comb begin
    driver.driving = driving_q;
    driver.data = data_q;
  end

endmodule

// ==== ebus_cmd_decode.sv ====
`include "ebus_config.svh"

module ebus_cmd_decode
  import ebus_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  ebus_cmd_t    cmd,
  input  logic         cmd_valid,
  output logic         cmd_ready,
  input  logic         advance,
  output ebus_strobe_t strobe
);

  localparam int half_slices = `EBUS_SLICES / 2;

  // Slices below the midpoint carry the right half of the word
  localparam logic [`EBUS_SLICES-1:0] right_mask = (`EBUS_SLICES)'((1 << half_slices) - 1);
  localparam logic [`EBUS_SLICES-1:0] left_mask = ~right_mask;

  logic                    accept;
  logic                    read_next;
  logic [`EBUS_SLICES-1:0] wen_next;
  ebus_word_u              wdata_next;

  logic                    valid_q;
  logic                    read_q;
  logic [`EBUS_SLICES-1:0] wen_q;
  logic [sel_w-1:0]        sel_q;
  ebus_word_u              wdata_q;

  assign cmd_ready = advance;
  assign accept = cmd_valid && cmd_ready;

  always_comb begin
    wdata_next = cmd.data;
    wen_next = '0;
    read_next = 1'b0;
    case (cmd.func)
      func_read: begin
        read_next = 1'b1;
      end
      func_write: begin
        wen_next = '1;
      end
      func_write_left: begin
        wen_next = left_mask;
      end
      func_write_right: begin
        wen_next = right_mask;
      end
      func_write_swap: begin
        wen_next = '1;
        wdata_next.half.left = cmd.data.half.right;
        wdata_next.half.right = cmd.data.half.left;
      end
      // Unused codes pass through as a bubble
      default: begin
        wen_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      read_q <= 1'b0;
      wen_q <= '0;
    end else if (advance) begin
      valid_q <= accept;
      read_q <= accept && read_next;
      wen_q <= accept ? wen_next : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      sel_q <= cmd.sel;
      wdata_q <= wdata_next;
    end
  end

  always_comb begin
    strobe.valid = valid_q;
    strobe.read = read_q;
    strobe.wen = wen_q;
    strobe.sel = sel_q;
    strobe.wdata = wdata_q;
  end

endmodule

// ==== ebus_pkg.sv ====
`include "ebus_config.svh"

package ebus_pkg;

  localparam int word_w = `EBUS_SLICES * `EBUS_SLICE_W;
  localparam int half_w = word_w / 2;
  localparam int sel_w = $clog2(`EBUS_REGS);

  // One bus word, seen whole or as left and right halves
  typedef union packed {
    logic [word_w-1:0] word;
    struct packed {
      logic [half_w-1:0] left;
      logic [half_w-1:0] right;
    } half;
  } ebus_word_u;

  typedef enum logic [2:0] {
    func_read        = 3'd0,
    func_write       = 3'd1,
    func_write_left  = 3'd2,
    func_write_right = 3'd3,
    func_write_swap  = 3'd4
  } ebus_func_e;

  typedef struct packed {
    ebus_func_e       func;
    logic [sel_w-1:0] sel;
    ebus_word_u       data;
  } ebus_cmd_t;

  // Stage 1, as seen by every slice board
  typedef struct packed {
    logic                    valid;
    logic                    read;
    logic [`EBUS_SLICES-1:0] wen;
    logic [sel_w-1:0]        sel;
    ebus_word_u              wdata;
  } ebus_strobe_t;

  typedef struct packed {
    logic                    driving;
    logic [`EBUS_SLICE_W-1:0] data;
  } ebus_driver_t;

  typedef struct packed {
    ebus_word_u word;
    logic       par;
  } ebus_resp_t;

endpackage

// ==== ebus_config.svh ====
`ifndef EBUS_CONFIG_SVH
`define EBUS_CONFIG_SVH

// Number of data-path slice boards on the bus
`define EBUS_SLICES 6

// Bits each slice board drives onto the word
`define EBUS_SLICE_W 6

// Diagnostic registers held across the slices
`define EBUS_REGS 8

`endif
